//--- hdl/exec_cfg.svh
`ifndef EXEC_CFG_SVH
`define EXEC_CFG_SVH

// Data path and address width
`define EXEC_XLEN 32

// Register file geometry
`define EXEC_NREGS 16
`define EXEC_RIDX_W 4

// Zero-extended for ALU operand b, sign-extended for branch offsets
`define EXEC_IMM_W 16

// r15 reads as the program counter
`define EXEC_PC_REG 15

// Flag bit positions inside the NZCV nibble
`define EXEC_FLAG_N 3
`define EXEC_FLAG_Z 2
`define EXEC_FLAG_C 1
`define EXEC_FLAG_V 0

`endif

//--- hdl/exec_pkg.sv
`include "exec_cfg.svh"

package exec_pkg;

    // ALU operations
    typedef enum logic [3:0] {
        MOV = 4'd0, // Result is operand b
        ADD = 4'd1,
        ADC = 4'd2,
        SUB = 4'd3,
        SBC = 4'd4,
        AND = 4'd5,
        OR  = 4'd6,
        XOR = 4'd7,
        BIC = 4'd8  // a and not b
    } alu_op_e;

    // Where the ALU result goes
    typedef enum logic [1:0] {
        NONE  = 2'd0, // Flags only
        RD    = 2'd1, // Write result to rd
        LOAD  = 2'd2, // Result is address, rd gets memory data
        STORE = 2'd3  // Result is address, rd is the data
    } dst_e;

    // Decoded control word, one per request
    typedef struct packed {
        alu_op_e                 aluop;
        dst_e                    dst;
        logic                    use_imm; // Immediate replaces register b
        logic                    setf;
        logic                    branch;
        logic [3:0]              cond;
        logic [`EXEC_RIDX_W-1:0] rd;
        logic [`EXEC_RIDX_W-1:0] rm;
        logic [`EXEC_RIDX_W-1:0] rn;
        logic [`EXEC_IMM_W-1:0]  imm;
    } exec_ctl_t;

    // Sequencer states
    typedef enum logic [2:0] {
        IDLE   = 3'd0,
        EXEC   = 3'd1,
        BRANCH = 3'd2,
        MEM    = 3'd3,
        WB     = 3'd4
    } state_e;

endpackage

//--- hdl/exec_regfile.sv
`timescale 1ns/1ps
`include "exec_cfg.svh"

module exec_regfile (
    input  logic                    clk,
    input  logic                    reset,
    // Read ports
    input  logic [`EXEC_RIDX_W-1:0] ra_i,
    input  logic [`EXEC_RIDX_W-1:0] rb_i,
    output logic [`EXEC_XLEN-1:0]   rdata_a_o,
    output logic [`EXEC_XLEN-1:0]   rdata_b_o,
    // Write port
    input  logic [`EXEC_RIDX_W-1:0] wa_i,
    input  logic                    we_i,
    input  logic [`EXEC_XLEN-1:0]   wdata_i
);

    logic [`EXEC_XLEN-1:0] regs_q [`EXEC_NREGS];

    // Entry 15 is shadowed by the PC in the sequencer
    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < `EXEC_NREGS; i++) begin
                regs_q[i] <= '0;
            end
        end else if (we_i) begin
            regs_q[wa_i] <= wdata_i;
        end
    end

    // Combinational reads, no bypass needed
    // since writes always land before the next IDLE cycle
    assign rdata_a_o = regs_q[ra_i];
    assign rdata_b_o = regs_q[rb_i];

endmodule

//--- hdl/exec_alu.sv
`timescale 1ns/1ps
`include "exec_cfg.svh"

module exec_alu (
    input  exec_pkg::alu_op_e     op_i,
    input  logic [`EXEC_XLEN-1:0] a_i,
    input  logic [`EXEC_XLEN-1:0] b_i,
    input  logic                  carry_i,   // Carry in for ADC and SBC
    input  logic [3:0]            flags_i,   // Current NZCV
    output logic [`EXEC_XLEN-1:0] res_o,
    output logic [3:0]            nzcv_o,
    // Branch condition lookup
    input  logic [3:0]            cond_i,
    output logic                  cond_true_o
);

    localparam int W = `EXEC_XLEN;

    logic [W-1:0] addend;
    logic         cin;
    logic         arith;
    logic [W:0]   sum;
    logic         c_out;
    logic         v_out;
    logic         fn, fz, fc, fv;
    logic [15:0]  conds;

    // Adder operand setup, subtraction is a + ~b + 1
    always_comb begin
        addend = b_i;
        cin    = 1'b0;
        arith  = 1'b1;
        case (op_i)
            exec_pkg::ADD: cin = 1'b0;
            exec_pkg::ADC: cin = carry_i;
            exec_pkg::SUB: begin
                addend = ~b_i;
                cin    = 1'b1;
            end
            exec_pkg::SBC: begin
                addend = ~b_i;
                cin    = carry_i; // Carry set means no borrow
            end
            default: arith = 1'b0;
        endcase
    end

    assign sum = {1'b0, a_i} + {1'b0, addend} + {{W{1'b0}}, cin};

    always_comb begin
        case (op_i)
            exec_pkg::ADD, exec_pkg::ADC,
            exec_pkg::SUB, exec_pkg::SBC: res_o = sum[W-1:0];
            exec_pkg::AND: res_o = a_i & b_i;
            exec_pkg::OR:  res_o = a_i | b_i;
            exec_pkg::XOR: res_o = a_i ^ b_i;
            exec_pkg::BIC: res_o = a_i & ~b_i;
            default:       res_o = b_i; // MOV
        endcase
    end

    // Logic ops and MOV leave C and V alone
    assign c_out = arith ? sum[W] : flags_i[`EXEC_FLAG_C];
    assign v_out = arith ? ((a_i[W-1] == addend[W-1]) && (sum[W-1] != a_i[W-1]))
                         : flags_i[`EXEC_FLAG_V];

    assign nzcv_o = {res_o[W-1], (res_o == '0), c_out, v_out};

    assign fn = flags_i[`EXEC_FLAG_N];
    assign fz = flags_i[`EXEC_FLAG_Z];
    assign fc = flags_i[`EXEC_FLAG_C];
    assign fv = flags_i[`EXEC_FLAG_V];

    assign conds[0]  = 1'b1;              // Always
    assign conds[1]  = fz;                // EQ
    assign conds[2]  = !fz;               // NE
    assign conds[3]  = fc;                // CS
    assign conds[4]  = !fc;               // NC
    assign conds[5]  = fn;                // SS
    assign conds[6]  = !fn;               // NS
    assign conds[7]  = fv;                // OV
    assign conds[8]  = !fv;               // NV
    assign conds[9]  = fc && !fz;         // AB
    assign conds[10] = !fc || fz;         // BE
    assign conds[11] = fn == fv;          // GE
    assign conds[12] = fn != fv;          // LT
    assign conds[13] = !fz && (fn == fv); // GT
    assign conds[14] = fz || (fn != fv);  // LE
    assign conds[15] = 1'b1;              // Always, no interrupt return here

    assign cond_true_o = conds[cond_i];

endmodule

//--- hdl/exec_mem_port.sv
`timescale 1ns/1ps
`include "exec_cfg.svh"

module exec_mem_port (
    input  logic                  clk,
    input  logic                  reset,
    // Sequencer side
    input  logic                  start_i,
    input  logic                  we_i,
    input  logic [`EXEC_XLEN-1:0] addr_i,
    input  logic [`EXEC_XLEN-1:0] wdata_i,
    output logic                  done_o,
    output logic [`EXEC_XLEN-1:0] rdata_o,
    // Memory bus
    output logic [`EXEC_XLEN-1:0] mem_addr_o,
    output logic [`EXEC_XLEN-1:0] mem_wdata_o,
    output logic                  mem_we_o,
    output logic                  mem_stb_o,
    input  logic [`EXEC_XLEN-1:0] mem_rdata_i,
    input  logic                  mem_ack_i,
    input  logic                  mem_stall_i
);

    logic busy_q;

    assign done_o = busy_q && mem_ack_i;

    always_ff @(posedge clk) begin
        if (reset) begin
            busy_q    <= 1'b0;
            mem_stb_o <= 1'b0;
            mem_we_o  <= 1'b0;
        end else if (start_i) begin
            busy_q    <= 1'b1;
            mem_stb_o <= 1'b1;
            mem_we_o  <= we_i;
        end else if (busy_q) begin
            if (!mem_stall_i) mem_stb_o <= 1'b0; // Strobe taken
            if (mem_ack_i) begin
                busy_q   <= 1'b0;
                mem_we_o <= 1'b0;
            end
        end
    end

    // Address and data hold steady for the whole access
    always_ff @(posedge clk) begin
        if (start_i) begin
            mem_addr_o  <= addr_i;
            mem_wdata_o <= wdata_i;
        end
        if (done_o) rdata_o <= mem_rdata_i;
    end

    a_no_ack_idle: assert property (@(posedge clk) disable iff (reset) mem_ack_i |-> busy_q);
    a_no_start_busy: assert property (@(posedge clk) disable iff (reset) start_i |-> !busy_q);

endmodule

//--- hdl/exec_sequencer.sv
`timescale 1ns/1ps
`include "exec_cfg.svh"

module exec_sequencer (
    input  logic                    clk,
    input  logic                    reset,
    // Request and fetch
    input  logic                    req_i,
    input  exec_pkg::exec_ctl_t     ctl_i,
    output logic                    rdy_o,
    output logic [`EXEC_XLEN-1:0]   newpc_o,
    output logic                    flush_o,
    // Register file
    output logic [`EXEC_RIDX_W-1:0] ra_o,
    output logic [`EXEC_RIDX_W-1:0] rb_o,
    output logic [`EXEC_RIDX_W-1:0] wa_o,
    output logic                    we_o,
    output logic [`EXEC_XLEN-1:0]   wdata_o,
    input  logic [`EXEC_XLEN-1:0]   rdata_a_i,
    input  logic [`EXEC_XLEN-1:0]   rdata_b_i,
    // ALU
    output exec_pkg::alu_op_e       alu_op_o,
    output logic [`EXEC_XLEN-1:0]   alu_a_o,
    output logic [`EXEC_XLEN-1:0]   alu_b_o,
    output logic                    carry_o,
    output logic [3:0]              flags_o,
    input  logic [`EXEC_XLEN-1:0]   alu_res_i,
    input  logic [3:0]              alu_nzcv_i,
    input  logic                    cond_true_i,
    // Memory port
    output logic                    mem_start_o,
    output logic                    mem_we_o,
    output logic [`EXEC_XLEN-1:0]   mem_addr_o,
    output logic [`EXEC_XLEN-1:0]   mem_wdata_o,
    input  logic                    mem_done_i,
    input  logic [`EXEC_XLEN-1:0]   mem_rdata_i
);

    localparam logic [`EXEC_RIDX_W-1:0] PC_IDX     = `EXEC_PC_REG;
    localparam logic [`EXEC_XLEN-1:0]   INSN_BYTES = 4;

    exec_pkg::state_e    state_q;
    exec_pkg::exec_ctl_t ctl_q;
    logic [`EXEC_XLEN-1:0] pc_q;
    logic [3:0]            flags_q;
    logic [`EXEC_XLEN-1:0] st_data_q; // rd value captured at accept
    logic [`EXEC_XLEN-1:0] rd_val;
    logic [`EXEC_XLEN-1:0] br_target;
    logic [`EXEC_XLEN-1:0] redir_pc;
    logic                  accept;
    logic                  is_mem;
    logic                  rd_is_pc;
    logic                  redirect;

    assign rdy_o    = state_q == exec_pkg::IDLE;
    assign accept   = req_i && rdy_o;
    assign is_mem   = (ctl_q.dst == exec_pkg::LOAD) || (ctl_q.dst == exec_pkg::STORE);
    assign rd_is_pc = ctl_q.rd == PC_IDX;

    // Port b reads rd while idle so store data is ready before EXEC
    assign ra_o   = ctl_q.rm;
    assign rb_o   = rdy_o ? ctl_i.rd : ctl_q.rn;
    assign rd_val = (ctl_i.rd == PC_IDX) ? pc_q + INSN_BYTES : rdata_b_i;

    // Operand select, r15 reads the already advanced PC
    assign alu_op_o = ctl_q.aluop;
    assign alu_a_o  = (ctl_q.rm == PC_IDX) ? pc_q : rdata_a_i;
    assign alu_b_o  = ctl_q.use_imm ? {{(`EXEC_XLEN-`EXEC_IMM_W){1'b0}}, ctl_q.imm}
                    : (ctl_q.rn == PC_IDX) ? pc_q : rdata_b_i;
    assign carry_o  = flags_q[`EXEC_FLAG_C];
    assign flags_o  = flags_q;

    // Own address is pc_q minus one instruction
    assign br_target = pc_q - INSN_BYTES
                     + {{(`EXEC_XLEN-`EXEC_IMM_W){ctl_q.imm[`EXEC_IMM_W-1]}}, ctl_q.imm};

    assign redirect = (state_q == exec_pkg::BRANCH)
                   || (state_q == exec_pkg::EXEC && ctl_q.dst == exec_pkg::RD && rd_is_pc)
                   || (state_q == exec_pkg::WB && rd_is_pc);
    assign redir_pc = (state_q == exec_pkg::BRANCH) ? br_target
                    : (state_q == exec_pkg::WB)     ? mem_rdata_i : alu_res_i;

    // Writes to r15 never reach the register file
    assign wa_o    = ctl_q.rd;
    assign we_o    = !rd_is_pc && ((state_q == exec_pkg::EXEC && ctl_q.dst == exec_pkg::RD)
                                || state_q == exec_pkg::WB);
    assign wdata_o = (state_q == exec_pkg::WB) ? mem_rdata_i : alu_res_i;

    assign mem_start_o = (state_q == exec_pkg::EXEC) && is_mem;
    assign mem_we_o    = ctl_q.dst == exec_pkg::STORE;
    assign mem_addr_o  = alu_res_i;
    assign mem_wdata_o = st_data_q;

    always_ff @(posedge clk) begin
        if (reset) begin
            state_q <= exec_pkg::IDLE;
            pc_q    <= '0;
            flags_q <= '0;
            flush_o <= 1'b0;
        end else begin
            flush_o <= redirect;
            if (redirect) pc_q <= redir_pc;
            case (state_q)
                exec_pkg::IDLE: if (accept) begin
                    pc_q <= pc_q + INSN_BYTES;
                    if (!ctl_i.branch) state_q <= exec_pkg::EXEC;
                    else if (cond_true_i) state_q <= exec_pkg::BRANCH; // Untaken stays idle
                end
                exec_pkg::EXEC: begin
                    if (ctl_q.setf) flags_q <= alu_nzcv_i;
                    if (is_mem) state_q <= exec_pkg::MEM;
                    else state_q <= exec_pkg::IDLE;
                end
                exec_pkg::MEM: if (mem_done_i) begin
                    if (ctl_q.dst == exec_pkg::LOAD) state_q <= exec_pkg::WB;
                    else state_q <= exec_pkg::IDLE;
                end
                default: state_q <= exec_pkg::IDLE; // BRANCH and WB last one cycle
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            ctl_q     <= ctl_i;
            st_data_q <= rd_val;
        end
        if (redirect) newpc_o <= redir_pc;
    end

    a_flush_pulse: assert property (@(posedge clk) disable iff (reset) flush_o |=> !flush_o);
    // EXEC is the cycle right after a non-branch word is accepted
    a_start_exec: assert property (@(posedge clk) disable iff (reset)
        mem_start_o |-> $past(accept && !ctl_i.branch));

endmodule

//--- hdl/exec_unit.sv
`timescale 1ns/1ps
`include "exec_cfg.svh"

module exec_unit (
    input  logic                  clk,
    input  logic                  reset,
    // Decode side
    input  logic                  req_i,
    input  exec_pkg::exec_ctl_t   ctl_i,
    output logic                  rdy_o,
    // Fetch redirect
    output logic [`EXEC_XLEN-1:0] newpc_o,
    output logic                  flush_o,
    // Memory bus
    output logic [`EXEC_XLEN-1:0] mem_addr_o,
    output logic [`EXEC_XLEN-1:0] mem_wdata_o,
    input  logic [`EXEC_XLEN-1:0] mem_rdata_i,
    output logic                  mem_we_o,
    output logic                  mem_stb_o,
    input  logic                  mem_ack_i,
    input  logic                  mem_stall_i
);

    logic [`EXEC_RIDX_W-1:0] ra, rb, wa;
    logic                    we;
    logic [`EXEC_XLEN-1:0]   wdata, rdata_a, rdata_b;
    exec_pkg::alu_op_e       alu_op;
    logic [`EXEC_XLEN-1:0]   alu_a, alu_b, alu_res;
    logic                    carry, cond_true;
    logic [3:0]              flags, alu_nzcv;
    logic                    mp_start, mp_we, mp_done;
    logic [`EXEC_XLEN-1:0]   mp_addr, mp_wdata, mp_rdata;

    exec_sequencer u_seq (
        .clk(clk), .reset(reset),
        .req_i(req_i), .ctl_i(ctl_i), .rdy_o(rdy_o),
        .newpc_o(newpc_o), .flush_o(flush_o),
        .ra_o(ra), .rb_o(rb), .wa_o(wa), .we_o(we), .wdata_o(wdata),
        .rdata_a_i(rdata_a), .rdata_b_i(rdata_b),
        .alu_op_o(alu_op), .alu_a_o(alu_a), .alu_b_o(alu_b),
        .carry_o(carry), .flags_o(flags),
        .alu_res_i(alu_res), .alu_nzcv_i(alu_nzcv), .cond_true_i(cond_true),
        .mem_start_o(mp_start), .mem_we_o(mp_we),
        .mem_addr_o(mp_addr), .mem_wdata_o(mp_wdata),
        .mem_done_i(mp_done), .mem_rdata_i(mp_rdata)
    );

    exec_regfile u_rf (
        .clk(clk), .reset(reset),
        .ra_i(ra), .rb_i(rb), .rdata_a_o(rdata_a), .rdata_b_o(rdata_b),
        .wa_i(wa), .we_i(we), .wdata_i(wdata)
    );

    // Branch decision is made while idle, on the incoming word
    exec_alu u_alu (
        .op_i(alu_op), .a_i(alu_a), .b_i(alu_b),
        .carry_i(carry), .flags_i(flags),
        .res_o(alu_res), .nzcv_o(alu_nzcv),
        .cond_i(ctl_i.cond), .cond_true_o(cond_true)
    );

    exec_mem_port u_mem (
        .clk(clk), .reset(reset),
        .start_i(mp_start), .we_i(mp_we), .addr_i(mp_addr), .wdata_i(mp_wdata),
        .done_o(mp_done), .rdata_o(mp_rdata),
        .mem_addr_o(mem_addr_o), .mem_wdata_o(mem_wdata_o),
        .mem_we_o(mem_we_o), .mem_stb_o(mem_stb_o),
        .mem_rdata_i(mem_rdata_i), .mem_ack_i(mem_ack_i), .mem_stall_i(mem_stall_i)
    );

endmodule

//--- sim/exec_tb.sv
`timescale 1ns/1ps
`include "exec_cfg.svh"

module exec_tb;

    localparam int TIMEOUT = 200;
    localparam int MEM_WORDS = 256;

    logic                  clk;
    logic                  reset;
    logic                  req_i;
    exec_pkg::exec_ctl_t   ctl_i;
    logic                  rdy_o;
    logic [`EXEC_XLEN-1:0] newpc_o;
    logic                  flush_o;
    logic [`EXEC_XLEN-1:0] mem_addr_o;
    logic [`EXEC_XLEN-1:0] mem_wdata_o;
    logic [`EXEC_XLEN-1:0] mem_rdata_i;
    logic                  mem_we_o;
    logic                  mem_stb_o;
    logic                  mem_ack_i;
    logic                  mem_stall_i;

    logic [`EXEC_XLEN-1:0] mem [MEM_WORDS];
    logic [`EXEC_XLEN-1:0] flush_q [$]; // Redirect targets seen on flush_o
    logic [`EXEC_XLEN-1:0] st_addr;     // Last store seen on the bus
    logic [`EXEC_XLEN-1:0] st_data;
    int                    errors;
    int                    checks;
    integer                seed;

    exec_unit dut (
        .clk(clk), .reset(reset),
        .req_i(req_i), .ctl_i(ctl_i), .rdy_o(rdy_o),
        .newpc_o(newpc_o), .flush_o(flush_o),
        .mem_addr_o(mem_addr_o), .mem_wdata_o(mem_wdata_o), .mem_rdata_i(mem_rdata_i),
        .mem_we_o(mem_we_o), .mem_stb_o(mem_stb_o),
        .mem_ack_i(mem_ack_i), .mem_stall_i(mem_stall_i)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // flush_o is registered, so it is settled shortly after the edge
    always @(posedge clk) begin
        #1;
        if (!reset && flush_o) flush_q.push_back(newpc_o);
    end

    task automatic compare_word(input string name, input logic [31:0] got,
                                input logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            $display("[FAIL] %s: got %08h, expected %08h", name, got, exp);
            errors++;
        end
    endtask

    task automatic abort_on_timeout(input string what);
        $display("Timed out after %0d cycles waiting for %s", TIMEOUT, what);
        errors++;
        $display("Checks: %0d, errors: %0d", checks, errors);
        $display("Test failures found");
        $finish;
    endtask

    task automatic wait_ready();
        int n;
        n = 0;
        while (!rdy_o) begin
            if (n == TIMEOUT) abort_on_timeout("rdy_o");
            @(negedge clk);
            n++;
        end
    endtask

    task automatic hold_check(input logic [31:0] addr, input logic [31:0] data, input logic we);
        compare_word("mem_addr_o", mem_addr_o, addr);
        compare_word("mem_wdata_o", mem_wdata_o, data);
        compare_word("mem_we_o", {31'd0, mem_we_o}, {31'd0, we});
    endtask

    // One bus access with random stall and acknowledge delay
    task automatic serve_mem();
        int n;
        int stalls;
        int delay;
        logic [31:0] addr;
        logic [31:0] data;
        logic we;
        n = 0;
        while (!mem_stb_o) begin
            if (n == TIMEOUT) abort_on_timeout("mem_stb_o");
            @(negedge clk);
            n++;
        end
        addr = mem_addr_o;
        data = mem_wdata_o;
        we = mem_we_o;
        stalls = $unsigned($random(seed)) % 4;
        delay = 1 + $unsigned($random(seed)) % 3;
        repeat (stalls) begin
            mem_stall_i = 1'b1;
            @(negedge clk);
            compare_word("mem_stb_o", {31'd0, mem_stb_o}, 32'd1); // Held while stalled
            hold_check(addr, data, we);
        end
        mem_stall_i = 1'b0;
        @(negedge clk); // Strobe taken at this edge
        hold_check(addr, data, we);
        compare_word("mem_stb_o", {31'd0, mem_stb_o}, 32'd0);
        repeat (delay - 1) begin
            @(negedge clk);
            hold_check(addr, data, we);
        end
        if (we) begin
            mem[addr[9:2]] = data;
            st_addr = addr;
            st_data = data;
        end else begin
            mem_rdata_i = mem[addr[9:2]];
        end
        mem_ack_i = 1'b1;
        @(negedge clk);
        mem_ack_i = 1'b0;
        mem_rdata_i = '0;
    endtask

    task automatic issue(input exec_pkg::exec_ctl_t c);
        wait_ready();
        if (flush_q.size() != 0) begin
            $display("Unexpected flush to %08h before the next request", flush_q[0]);
            errors++;
            flush_q.delete();
        end
        req_i = 1'b1;
        ctl_i = c;
        @(negedge clk);
        req_i = 1'b0;
        if (c.dst == exec_pkg::LOAD || c.dst == exec_pkg::STORE) serve_mem();
    endtask

    task automatic expect_flush(input logic [31:0] exp);
        int n;
        n = 0;
        while (flush_q.size() == 0) begin
            if (n == TIMEOUT) abort_on_timeout("flush_o");
            @(negedge clk);
            n++;
        end
        compare_word("newpc_o", flush_q.pop_front(), exp);
    endtask

    initial begin
        int fd;
        int code;
        byte kind;
        bit done;
        string line;
        logic [31:0] a, d;
        logic [31:0] op, dst, ui, sf, br, cd, rd, rm, rn, imm;
        exec_pkg::exec_ctl_t c;
        reset = 1'b1;
        req_i = 1'b0;
        ctl_i = '0;
        mem_rdata_i = '0;
        mem_ack_i = 1'b0;
        mem_stall_i = 1'b0;
        errors = 0;
        checks = 0;
        seed = 91;
        st_addr = '0;
        st_data = '0;
        for (int i = 0; i < MEM_WORDS; i++) mem[i] = 32'h5A5A0000 ^ (i << 2);
        repeat (5) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;
        @(negedge clk);
        compare_word("rdy_o", {31'd0, rdy_o}, 32'd1);
        compare_word("flush_o", {31'd0, flush_o}, 32'd0);
        compare_word("mem_stb_o", {31'd0, mem_stb_o}, 32'd0);
        compare_word("mem_we_o", {31'd0, mem_we_o}, 32'd0);

        fd = $fopen("sim/exec_trace.txt", "r");
        if (fd == 0) begin
            $display("Cannot open the trace file sim/exec_trace.txt");
            errors++;
        end else begin
            done = 0;
            while (!done) begin
                code = $fscanf(fd, " %c", kind);
                if (code != 1) begin
                    $display("Trace ended without an end record");
                    errors++;
                    done = 1;
                end else begin
                    case (kind)
                        "#": code = $fgets(line, fd);
                        "M": begin
                            code = $fscanf(fd, "%h %h", a, d);
                            mem[a[9:2]] = d;
                        end
                        "I": begin
                            code = $fscanf(fd, "%h %h %h %h %h %h %h %h %h %h",
                                           op, dst, ui, sf, br, cd, rd, rm, rn, imm);
                            c.aluop = exec_pkg::alu_op_e'(op[3:0]);
                            c.dst = exec_pkg::dst_e'(dst[1:0]);
                            c.use_imm = ui[0];
                            c.setf = sf[0];
                            c.branch = br[0];
                            c.cond = cd[3:0];
                            c.rd = rd[3:0];
                            c.rm = rm[3:0];
                            c.rn = rn[3:0];
                            c.imm = imm[15:0];
                            issue(c);
                        end
                        "S": begin
                            code = $fscanf(fd, "%h %h", a, d);
                            compare_word("store mem_addr_o", st_addr, a);
                            compare_word("store mem_wdata_o", st_data, d);
                        end
                        "F": begin
                            code = $fscanf(fd, "%h", a);
                            expect_flush(a);
                        end
                        "E": done = 1;
                        default: begin
                            $display("Unknown trace record '%c'", kind);
                            errors++;
                            done = 1;
                        end
                    endcase
                end
            end
            $fclose(fd);
        end

        wait_ready();
        if (flush_q.size() != 0) begin
            $display("Flush to %08h left over at the end of the trace", flush_q[0]);
            errors++;
        end
        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

//--- sim/exec_trace.txt
# M addr data | I op dst use_imm setf branch cond rd rm rn imm | S addr data | F newpc | E
# All fields hex; ops MOV0 ADD1 ADC2 SUB3 SBC4 AND5 OR6 XOR7 BIC8; dst NONE0 RD1 LOAD2 STORE3
M 00000040 7fffffff
M 00000044 80000000
M 00000048 cafef00d
M 0000004c 00000300
I 0 1 1 0 0 0 1 0 0 1234
I 0 1 1 0 0 0 2 0 0 00ff
I 0 1 1 0 0 0 3 0 0 0100
I 1 1 0 0 0 0 4 1 2 0000
I 1 3 1 0 0 0 4 3 0 0000
S 00000100 00001333
I 3 1 0 0 0 0 5 1 2 0000
I 1 3 1 0 0 0 5 3 0 0004
S 00000104 00001135
I 5 1 0 0 0 0 6 1 2 0000
I 1 3 1 0 0 0 6 3 0 0008
S 00000108 00000034
I 6 1 0 0 0 0 7 1 2 0000
I 1 3 1 0 0 0 7 3 0 000c
S 0000010c 000012ff
I 7 1 0 0 0 0 8 1 2 0000
I 1 3 1 0 0 0 8 3 0 0010
S 00000110 000012cb
I 8 1 0 0 0 0 9 1 2 0000
I 1 3 1 0 0 0 9 3 0 0014
S 00000114 00001200
I 3 0 0 1 0 0 0 1 1 0000
I 0 0 0 0 1 1 0 0 0 0010
F 00000050
I 0 0 0 0 1 2 0 0 0 0008
I 3 0 0 1 0 0 0 1 2 0000
I 0 0 0 0 1 2 0 0 0 fff8
F 00000050
I 0 0 0 0 1 1 0 0 0 0100
I 0 2 1 0 0 0 a 0 0 0040
I 1 0 1 1 0 0 0 a 0 0001
I 0 0 0 0 1 7 0 0 0 0020
F 0000007c
I 0 0 0 0 1 b 0 0 0 0004
F 00000080
I 0 0 0 0 1 c 0 0 0 0040
I 0 2 1 0 0 0 b 0 0 0044
I 1 0 0 1 0 0 0 b b 0000
I 0 0 0 0 1 3 0 0 0 fff0
F 0000007c
I 0 0 0 0 1 9 0 0 0 0008
I 0 0 0 0 1 a 0 0 0 0040
F 000000c0
I 0 0 0 0 1 f 0 0 0 0010
F 000000d0
I 0 2 1 0 0 0 c 0 0 0048
I 1 3 1 0 0 0 c 3 0 0020
S 00000120 cafef00d
I 0 2 1 0 0 0 d 0 0 0200
I 1 3 1 0 0 0 d 3 0 0024
S 00000124 5a5a0200
I 1 3 1 0 0 0 a 3 0 0028
S 00000128 7fffffff
I 0 2 1 0 0 0 e 0 0 0120
I 1 3 1 0 0 0 e 3 0 002c
S 0000012c cafef00d
I 0 1 1 0 0 0 f 0 0 0200
F 00000200
I 0 0 0 0 1 0 0 0 0 0010
F 00000210
I 0 2 1 0 0 0 f 0 0 004c
F 00000300
I 0 0 0 0 1 0 0 0 0 ff00
F 00000200
E

//--- flist.f
+incdir+hdl
hdl/exec_pkg.sv
hdl/exec_regfile.sv
hdl/exec_alu.sv
hdl/exec_mem_port.sv
hdl/exec_sequencer.sv
hdl/exec_unit.sv
sim/exec_tb.sv

//--- Makefile
# Verilator build and run of the execute stage testbench

LOG := sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, check $(LOG)"
	@echo "  clean  remove build output and log"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert -f flist.f --top-module exec_tb -o Vexec_tb
	obj_dir/Vexec_tb | tee $(LOG)
	@if grep -q "All tests passed!" $(LOG); then \
		echo "PASS"; \
	else \
		echo "FAIL"; \
		exit 1; \
	fi

clean:
	rm -rf obj_dir $(LOG)
